// File: common/harness_cfg_pkg.sv
// ##########################################################################
// Harness configuration
// Switch cell latency, power domain counts and GPIO counter limit
// ##########################################################################

package harness_cfg_pkg;

  // Power-switch cell emulation
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // Memory banks with a switch of their own
  localparam int unsigned NUM_BANKS = 2;

  // External power domains
  localparam int unsigned EXT_DOMAINS = 1;

  // Active-low switch masks
  typedef logic [NUM_BANKS-1:0] bank_mask_t;
  typedef logic [EXT_DOMAINS-1:0] domain_mask_t;

  // High input cycles per output pulse
  localparam logic [31:0] GPIO_CNT_MAX = 32'd2048;

endpackage

// File: common/obi_bus_pkg.sv
// ##########################################################################
// OBI bus definitions
// Bus widths, payload types and slow memory timing
// ##########################################################################

package obi_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [DATA_W/8-1:0] be_t;

  // Slow memory geometry, word index from address bits 15:2
  localparam int unsigned MEM_NUM_WORDS = 8192;
  localparam int unsigned MEM_IDX_W = 14;

  // Queue depth and outstanding limit
  localparam int unsigned OBI_FIFO_DEPTH = 4;

  // Slow memory timing in cycles
  localparam int unsigned SLOW_MEM_GNT_DELAY = 2;
  localparam int unsigned SLOW_MEM_READ_LATENCY = 3;

endpackage

// File: src/switch_ack_delay.sv
// ##########################################################################
// Power-switch cell model
// Returns each switch request as an acknowledge after a fixed delay
// ##########################################################################

`timescale 1ns/1ps

module switch_ack_delay #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t switch_n_i,
  output payload_t switch_ack_n_o
);

  localparam int unsigned DEPTH = harness_cfg_pkg::SWITCH_ACK_LATENCY;

  payload_t stage_q [DEPTH];

  // Ones mean not acknowledged until the line has filled
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[DEPTH-1];

endmodule

// File: src/gpio_cnt.sv
// ##########################################################################
// GPIO counter device
// Pulses the output pin once per run of high input samples
// ##########################################################################

`timescale 1ns/1ps

module gpio_cnt (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  localparam logic [31:0] CNT_LAST = harness_cfg_pkg::GPIO_CNT_MAX - 32'd1;

  logic [31:0] cnt_q;
  logic        pulse_q;
  logic        cnt_done;

  assign cnt_done = (cnt_q == CNT_LAST);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= '0;
      pulse_q <= 1'b0;
    end else begin
      if (!gpio_i) begin
        // Any low sample restarts the run
        cnt_q   <= '0;
        pulse_q <= 1'b0;
      end else if (cnt_done) begin
        cnt_q   <= '0;
        pulse_q <= 1'b1;
      end else begin
        cnt_q   <= cnt_q + 32'd1;
        pulse_q <= 1'b0;
      end
    end
  end

  // One cycle pulse after the last counted sample
  assign gpio_o = pulse_q;

endmodule

// File: slow_mem/obi_fifo.sv
// ##########################################################################
// OBI request/response FIFO
// Queues requests and responses between a producer and a slow slave
// ##########################################################################

`timescale 1ns/1ps

module obi_fifo (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               prod_req_i,
  input  logic               prod_we_i,
  input  obi_bus_pkg::be_t   prod_be_i,
  input  obi_bus_pkg::addr_t prod_addr_i,
  input  obi_bus_pkg::data_t prod_wdata_i,
  output logic               prod_gnt_o,
  output logic               prod_rvalid_o,
  output obi_bus_pkg::data_t prod_rdata_o,
  output logic               cons_req_o,
  output logic               cons_we_o,
  output obi_bus_pkg::be_t   cons_be_o,
  output obi_bus_pkg::addr_t cons_addr_o,
  output obi_bus_pkg::data_t cons_wdata_o,
  input  logic               cons_gnt_i,
  input  logic               cons_rvalid_i,
  input  obi_bus_pkg::data_t cons_rdata_i
);

  localparam int unsigned DEPTH = obi_bus_pkg::OBI_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned REQ_W = 1 + $bits(obi_bus_pkg::be_t) + obi_bus_pkg::ADDR_W +
                                  obi_bus_pkg::DATA_W;

  logic [REQ_W-1:0]   req_mem_q [DEPTH];
  logic [PTR_W-1:0]   req_wr_ptr_q, req_rd_ptr_q;
  logic [CNT_W-1:0]   req_cnt_q;
  obi_bus_pkg::data_t rsp_mem_q [DEPTH];
  logic [PTR_W-1:0]   rsp_wr_ptr_q, rsp_rd_ptr_q;
  logic [CNT_W-1:0]   rsp_cnt_q;
  logic [CNT_W-1:0]   outst_q;
  logic               prod_accept;
  logic               cons_accept;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Grant only while a response slot is still free
  assign prod_gnt_o  = prod_req_i && (outst_q < CNT_W'(DEPTH));
  assign prod_accept = prod_req_i && prod_gnt_o;
  assign cons_accept = cons_req_o && cons_gnt_i;

  assign cons_req_o = (req_cnt_q != '0);
  assign {cons_we_o, cons_be_o, cons_addr_o, cons_wdata_o} = req_mem_q[req_rd_ptr_q];

  assign prod_rvalid_o = (rsp_cnt_q != '0);
  assign prod_rdata_o  = rsp_mem_q[rsp_rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_wr_ptr_q <= '0;
      req_rd_ptr_q <= '0;
      req_cnt_q    <= '0;
      rsp_wr_ptr_q <= '0;
      rsp_rd_ptr_q <= '0;
      rsp_cnt_q    <= '0;
      outst_q      <= '0;
    end else begin
      if (prod_accept) req_wr_ptr_q <= ptr_next(req_wr_ptr_q);
      if (cons_accept) req_rd_ptr_q <= ptr_next(req_rd_ptr_q);
      if (prod_accept && !cons_accept) req_cnt_q <= req_cnt_q + 1'b1;
      if (!prod_accept && cons_accept) req_cnt_q <= req_cnt_q - 1'b1;

      // Producer always takes the response, so pop whenever one is there
      if (cons_rvalid_i) rsp_wr_ptr_q <= ptr_next(rsp_wr_ptr_q);
      if (prod_rvalid_o) rsp_rd_ptr_q <= ptr_next(rsp_rd_ptr_q);
      if (cons_rvalid_i && !prod_rvalid_o) rsp_cnt_q <= rsp_cnt_q + 1'b1;
      if (!cons_rvalid_i && prod_rvalid_o) rsp_cnt_q <= rsp_cnt_q - 1'b1;

      if (prod_accept && !prod_rvalid_o) outst_q <= outst_q + 1'b1;
      if (!prod_accept && prod_rvalid_o) outst_q <= outst_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (prod_accept) begin
      req_mem_q[req_wr_ptr_q] <= {prod_we_i, prod_be_i, prod_addr_i, prod_wdata_i};
    end
    if (cons_rvalid_i) begin
      rsp_mem_q[rsp_wr_ptr_q] <= cons_rdata_i;
    end
  end

endmodule

// File: slow_mem/slow_memory.sv
// ##########################################################################
// Slow memory model
// Word memory with byte enables, delayed grant and fixed read latency
// ##########################################################################

`timescale 1ns/1ps

module slow_memory (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  obi_bus_pkg::be_t                  be_i,
  input  logic [obi_bus_pkg::MEM_IDX_W-1:0] addr_i,
  input  obi_bus_pkg::data_t                wdata_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output obi_bus_pkg::data_t                rdata_o
);

  localparam int unsigned WAIT_W = $clog2(obi_bus_pkg::SLOW_MEM_GNT_DELAY + 2);
  localparam int unsigned LAT    = obi_bus_pkg::SLOW_MEM_READ_LATENCY;
  localparam int unsigned ROW_W  = $clog2(obi_bus_pkg::MEM_NUM_WORDS);
  localparam int unsigned LANES  = obi_bus_pkg::DATA_W / 8;

  logic [WAIT_W-1:0]  wait_cnt_q;
  logic [ROW_W-1:0]   row;
  obi_bus_pkg::data_t mem_q [obi_bus_pkg::MEM_NUM_WORDS];
  logic [LAT-1:0]     valid_q;
  obi_bus_pkg::data_t data_q [LAT];

  // Upper index bits alias onto the array
  assign row = addr_i[ROW_W-1:0];

  assign gnt_o = req_i && (wait_cnt_q == WAIT_W'(obi_bus_pkg::SLOW_MEM_GNT_DELAY));

  // Wait counter restarts after each grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_cnt_q <= '0;
    end else if (!req_i || gnt_o) begin
      wait_cnt_q <= '0;
    end else begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= gnt_o;
      for (int i = 1; i < LAT; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o && we_i) begin
      for (int b = 0; b < LANES; b++) begin
        if (be_i[b]) mem_q[row][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
    // Writes answer with zero data
    data_q[0] <= (gnt_o && !we_i) ? mem_q[row] : '0;
    for (int i = 1; i < LAT; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign rvalid_o = valid_q[LAT-1];
  assign rdata_o  = data_q[LAT-1];

endmodule

// File: src/ext_harness_top.sv
// ##########################################################################
// External harness top
// Slow memory path, power-switch cell models and GPIO counter device
// ##########################################################################

`timescale 1ns/1ps

module ext_harness_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         obi_req_i,
  input  logic                         obi_we_i,
  input  obi_bus_pkg::be_t             obi_be_i,
  input  obi_bus_pkg::addr_t           obi_addr_i,
  input  obi_bus_pkg::data_t           obi_wdata_i,
  output logic                         obi_gnt_o,
  output logic                         obi_rvalid_o,
  output obi_bus_pkg::data_t           obi_rdata_o,
  input  logic                         cpu_switch_n_i,
  output logic                         cpu_switch_ack_n_o,
  input  logic                         periph_switch_n_i,
  output logic                         periph_switch_ack_n_o,
  input  harness_cfg_pkg::bank_mask_t   bank_switch_n_i,
  output harness_cfg_pkg::bank_mask_t   bank_switch_ack_n_o,
  input  harness_cfg_pkg::domain_mask_t ext_switch_n_i,
  output harness_cfg_pkg::domain_mask_t ext_switch_ack_n_o,
  input  logic                         gpio_i,
  output logic                         gpio_o
);

  // FIFO to memory
  logic               mem_req;
  logic               mem_we;
  obi_bus_pkg::be_t   mem_be;
  obi_bus_pkg::addr_t mem_addr;
  obi_bus_pkg::data_t mem_wdata;
  logic               mem_gnt;
  logic               mem_rvalid;
  obi_bus_pkg::data_t mem_rdata;

  // Adds latency in front of the slow memory
  obi_fifo obi_fifo_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .prod_req_i    (obi_req_i),
    .prod_we_i     (obi_we_i),
    .prod_be_i     (obi_be_i),
    .prod_addr_i   (obi_addr_i),
    .prod_wdata_i  (obi_wdata_i),
    .prod_gnt_o    (obi_gnt_o),
    .prod_rvalid_o (obi_rvalid_o),
    .prod_rdata_o  (obi_rdata_o),
    .cons_req_o    (mem_req),
    .cons_we_o     (mem_we),
    .cons_be_o     (mem_be),
    .cons_addr_o   (mem_addr),
    .cons_wdata_o  (mem_wdata),
    .cons_gnt_i    (mem_gnt),
    .cons_rvalid_i (mem_rvalid),
    .cons_rdata_i  (mem_rdata)
  );

  slow_memory slow_memory_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .be_i     (mem_be),
    .addr_i   (mem_addr[15:2]),
    .wdata_i  (mem_wdata),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  // Switch cells, one per power domain group
  switch_ack_delay #(.payload_t(logic)) cpu_switch_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (cpu_switch_n_i),
    .switch_ack_n_o (cpu_switch_ack_n_o)
  );

  switch_ack_delay #(.payload_t(logic)) periph_switch_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (periph_switch_n_i),
    .switch_ack_n_o (periph_switch_ack_n_o)
  );

  switch_ack_delay #(.payload_t(harness_cfg_pkg::bank_mask_t)) bank_switch_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (bank_switch_n_i),
    .switch_ack_n_o (bank_switch_ack_n_o)
  );

  switch_ack_delay #(.payload_t(harness_cfg_pkg::domain_mask_t)) ext_switch_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (ext_switch_n_i),
    .switch_ack_n_o (ext_switch_ack_n_o)
  );

  gpio_cnt gpio_cnt_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o)
  );

endmodule

// File: tests/tb_ext_harness.sv
// ##########################################################################
// External harness testbench
// Checks slow memory path, switch cell models and GPIO counter
// ##########################################################################

`timescale 1ns/1ps

module tb_ext_harness;

  localparam int SW_LAT      = harness_cfg_pkg::SWITCH_ACK_LATENCY;
  localparam int GPIO_MAX    = harness_cfg_pkg::GPIO_CNT_MAX;
  localparam int FIFO_DEPTH  = obi_bus_pkg::OBI_FIFO_DEPTH;
  localparam int NUM_WORDS   = obi_bus_pkg::MEM_NUM_WORDS;
  localparam int NUM_ADDR    = 16;
  localparam int SW_W        = 2 + $bits(harness_cfg_pkg::bank_mask_t) +
                               $bits(harness_cfg_pkg::domain_mask_t);
  // Twice the GPIO phase plus 64 memory transactions of 40 cycles
  localparam int CYCLE_LIMIT = 2 * ((3 * GPIO_MAX + 100) + 64 * 40);
  // Cycles allowed for all open responses to come back
  localparam int DRAIN_LIMIT = 40 * NUM_ADDR;

  logic                          clk;
  logic                          arst_n;
  logic                          obi_req;
  logic                          obi_we;
  obi_bus_pkg::be_t              obi_be;
  obi_bus_pkg::addr_t            obi_addr;
  obi_bus_pkg::data_t            obi_wdata;
  logic                          obi_gnt;
  logic                          obi_rvalid;
  obi_bus_pkg::data_t            obi_rdata;
  logic                          cpu_sw_n;
  logic                          cpu_ack_n;
  logic                          periph_sw_n;
  logic                          periph_ack_n;
  harness_cfg_pkg::bank_mask_t   bank_sw_n;
  harness_cfg_pkg::bank_mask_t   bank_ack_n;
  harness_cfg_pkg::domain_mask_t ext_sw_n;
  harness_cfg_pkg::domain_mask_t ext_ack_n;
  logic                          gpio_in;
  logic                          gpio_out;

  string              test_name;
  int                 cycle_cnt = 0;
  obi_bus_pkg::data_t exp_rsp_q [$];
  obi_bus_pkg::data_t model_mem [int];
  obi_bus_pkg::addr_t addr_list [NUM_ADDR];
  int                 rsp_idx = 0;
  int                 pending = 0;
  int                 stall_cnt = 0;
  int                 stall_start;
  logic [SW_W-1:0]    sw_hist_q [$];
  logic [SW_W-1:0]    sw_exp;
  int                 gpio_run = 0;
  logic               gpio_exp = 1'b0;
  int                 gpio_pulses = 0;
  int                 pulse_start;

  ext_harness_top ext_harness_top_inst (
    .clk_i                 (clk),
    .arst_n_i              (arst_n),
    .obi_req_i             (obi_req),
    .obi_we_i              (obi_we),
    .obi_be_i              (obi_be),
    .obi_addr_i            (obi_addr),
    .obi_wdata_i           (obi_wdata),
    .obi_gnt_o             (obi_gnt),
    .obi_rvalid_o          (obi_rvalid),
    .obi_rdata_o           (obi_rdata),
    .cpu_switch_n_i        (cpu_sw_n),
    .cpu_switch_ack_n_o    (cpu_ack_n),
    .periph_switch_n_i     (periph_sw_n),
    .periph_switch_ack_n_o (periph_ack_n),
    .bank_switch_n_i       (bank_sw_n),
    .bank_switch_ack_n_o   (bank_ack_n),
    .ext_switch_n_i        (ext_sw_n),
    .ext_switch_ack_n_o    (ext_ack_n),
    .gpio_i                (gpio_in),
    .gpio_o                (gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic string mismatch_text(input string what, input logic [31:0] exp_val,
                                          input logic [31:0] act_val);
    return $sformatf("MISMATCH %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, exp_val, act_val);
  endfunction

  // Issue one request and hold it until granted
  task automatic issue(input logic we, input obi_bus_pkg::be_t be,
                       input obi_bus_pkg::addr_t addr, input obi_bus_pkg::data_t wdata);
    int                 idx;
    obi_bus_pkg::data_t word;
    idx = int'(addr[14:2]);
    if (we) begin
      word = model_mem.exists(idx) ? model_mem[idx] : '0;
      for (int b = 0; b < 4; b++) begin
        if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];
      end
      model_mem[idx] = word;
      exp_rsp_q.push_back('0);
    end else begin
      exp_rsp_q.push_back(model_mem[idx]);
    end
    obi_req   <= 1'b1;
    obi_we    <= we;
    obi_be    <= be;
    obi_addr  <= addr;
    obi_wdata <= wdata;
    @(negedge clk);
    while (!obi_gnt) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    obi_req <= 1'b0;
    @(posedge clk);
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      waited++;
      @(posedge clk);
    end
    assert (rsp_idx == exp_rsp_q.size())
      else report_fail($sformatf("Test %s got %0d responses for %0d requests",
                                 test_name, rsp_idx, exp_rsp_q.size()));
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < CYCLE_LIMIT)
      else report_fail($sformatf("Run did not finish within %0d cycles, stuck in test %s",
                                 CYCLE_LIMIT, test_name));
  end

  // Response order, outstanding limit and back-pressure tracking
  always @(negedge clk) begin
    if (arst_n) begin
      if (obi_rvalid) begin
        assert (pending > 0)
          else report_fail($sformatf("rvalid without an outstanding request in test %s",
                                     test_name));
        assert (obi_rdata === exp_rsp_q[rsp_idx])
          else report_fail(mismatch_text("obi_rdata_o", exp_rsp_q[rsp_idx], obi_rdata));
        rsp_idx++;
        pending--;
      end
      if (obi_req && obi_gnt) pending++;
      if (obi_req && !obi_gnt) stall_cnt++;
      assert (pending <= FIFO_DEPTH)
        else report_fail($sformatf("%0d requests outstanding in test %s, limit is %0d",
                                   pending, test_name, FIFO_DEPTH));
    end
  end

  // Switch cells against their input history
  always @(negedge clk) begin
    if (arst_n) begin
      sw_hist_q.push_back({cpu_sw_n, periph_sw_n, bank_sw_n, ext_sw_n});
      sw_exp = {SW_W{1'b1}};
      if (sw_hist_q.size() > SW_LAT) sw_exp = sw_hist_q.pop_front();
      assert ({cpu_ack_n, periph_ack_n, bank_ack_n, ext_ack_n} === sw_exp)
        else report_fail(mismatch_text("switch_ack_n", 32'(sw_exp),
                                       32'({cpu_ack_n, periph_ack_n, bank_ack_n, ext_ack_n})));
    end
  end

  // GPIO counter model
  // Input here is what the next edge samples
  always @(negedge clk) begin
    if (arst_n) begin
      assert (gpio_out === gpio_exp)
        else report_fail(mismatch_text("gpio_o", 32'(gpio_exp), 32'(gpio_out)));
      if (gpio_out) gpio_pulses++;
      if (!gpio_in) begin
        gpio_run = 0;
        gpio_exp = 1'b0;
      end else if (gpio_run == GPIO_MAX - 1) begin
        gpio_run = 0;
        gpio_exp = 1'b1;
      end else begin
        gpio_run++;
        gpio_exp = 1'b0;
      end
    end
  end

  initial begin
    void'($urandom(32'h589c_0cc6));
    test_name = "reset";
    arst_n      <= 1'b0;
    obi_req     <= 1'b0;
    obi_we      <= 1'b0;
    obi_be      <= '0;
    obi_addr    <= '0;
    obi_wdata   <= '0;
    cpu_sw_n    <= 1'b1;
    periph_sw_n <= 1'b1;
    bank_sw_n   <= '1;
    ext_sw_n    <= '1;
    gpio_in     <= 1'b0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (obi_gnt === 1'b0) else report_fail(mismatch_text("obi_gnt_o", 32'd0, 32'(obi_gnt)));
    assert (obi_rvalid === 1'b0)
      else report_fail(mismatch_text("obi_rvalid_o", 32'd0, 32'(obi_rvalid)));
    assert (gpio_out === 1'b0) else report_fail(mismatch_text("gpio_o", 32'd0, 32'(gpio_out)));
    assert ({cpu_ack_n, periph_ack_n, bank_ack_n, ext_ack_n} === {SW_W{1'b1}})
      else report_fail(mismatch_text("switch_ack_n", 32'({SW_W{1'b1}}),
                                     32'({cpu_ack_n, periph_ack_n, bank_ack_n, ext_ack_n})));
    @(posedge clk);

    // Full word first so no byte stays unknown
    test_name = "mem_write_read";
    for (int i = 0; i < NUM_ADDR; i++) begin
      addr_list[i] = obi_bus_pkg::addr_t'($urandom_range(NUM_WORDS - 1, 0)) << 2;
      issue(1'b1, '1, addr_list[i], $urandom());
      wait_drain();
    end
    for (int i = 0; i < NUM_ADDR; i++) begin
      issue(1'b1, obi_bus_pkg::be_t'($urandom()), addr_list[i], $urandom());
      wait_drain();
    end
    for (int i = 0; i < NUM_ADDR; i++) begin
      issue(1'b0, '0, addr_list[i], '0);
      wait_drain();
    end

    test_name = "back_pressure";
    stall_start = stall_cnt;
    for (int i = 0; i < NUM_ADDR / 2; i++) begin
      issue(1'b1, obi_bus_pkg::be_t'($urandom()), addr_list[i], $urandom());
    end
    for (int i = 0; i < NUM_ADDR / 2; i++) begin
      issue(1'b0, '0, addr_list[i], '0);
    end
    wait_drain();
    assert (stall_cnt > stall_start)
      else report_fail("Grant never dropped while requests came back to back");

    test_name = "switch_ack";
    repeat (4 * SW_LAT) begin
      {cpu_sw_n, periph_sw_n, bank_sw_n, ext_sw_n} <= SW_W'($urandom());
      @(posedge clk);
    end
    {cpu_sw_n, periph_sw_n, bank_sw_n, ext_sw_n} <= {SW_W{1'b1}};
    repeat (SW_LAT + 2) @(posedge clk);

    // Two runs one sample short of the limit with a short low gap between
    test_name = "gpio_gap";
    pulse_start = gpio_pulses;
    repeat (2) begin
      gpio_in <= 1'b1;
      repeat (GPIO_MAX - 1) @(posedge clk);
      gpio_in <= 1'b0;
      repeat (3) @(posedge clk);
    end
    assert (gpio_pulses == pulse_start)
      else report_fail(mismatch_text("gpio pulses", 32'd0, gpio_pulses - pulse_start));

    test_name = "gpio_run";
    pulse_start = gpio_pulses;
    gpio_in <= 1'b1;
    repeat (3 * GPIO_MAX) @(posedge clk);
    gpio_in <= 1'b0;
    repeat (3) @(posedge clk);
    assert (gpio_pulses - pulse_start == 3)
      else report_fail(mismatch_text("gpio pulses", 32'd3, gpio_pulses - pulse_start));

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: src.f
common/harness_cfg_pkg.sv
common/obi_bus_pkg.sv
src/switch_ack_delay.sv
src/gpio_cnt.sv
slow_mem/obi_fifo.sv
slow_mem/slow_memory.sv
src/ext_harness_top.sv
tests/tb_ext_harness.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
# A failing run ends in $fatal and gives a non-zero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ext_harness \
  --Mdir obj_dir -o tb_ext_harness \
  -f src.f

./obj_dir/tb_ext_harness
